// ==== hw/opq_pkg.sv ====
/*
 * Shared widths, depths and encodings of the vector operand queue.
 * Integer widening only. Words are 64 bits with elements in natural byte order.
 */

`default_nettype none

package opq_pkg;

  // Operand word geometry
  localparam int unsigned ElenWidth = 64;
  localparam int unsigned ElenBytes = ElenWidth / 8;
  localparam int unsigned SelWidth  = 3;

  // Buffer depths
  localparam int unsigned CmdDepth  = 2;
  localparam int unsigned DataDepth = 2;

  // Credit count spans 0..DataDepth
  localparam int unsigned CreditWidth = 2;

  localparam int unsigned ElemCntWidth = 16;

  // Source element width
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Integer conversion applied to each source element
  typedef enum logic [2:0] {
    ConvNone  = 3'd0,
    ConvSExt2 = 3'd1,
    ConvZExt2 = 3'd2,
    ConvSExt4 = 3'd3,
    ConvZExt4 = 3'd4,
    ConvSExt8 = 3'd5,
    ConvZExt8 = 3'd6
  } conv_e;

  // Packed command word, {eew, conv, elem_count}
  localparam int unsigned CmdWidth = $bits(eew_e) + $bits(conv_e) + ElemCntWidth;

endpackage

`default_nettype wire

// ==== hw/opq_fifo.sv ====
/*
 * Fall-through FIFO, the head is visible in the cycle after its push.
 * A push into a full FIFO is dropped unless a pop happens in the same cycle.
 */

`default_nettype none

module opq_fifo #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [Width-1:0] data_i,
  input  logic             pop_i,
  output logic [Width-1:0] data_o,
  output logic             empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  logic [Width-1:0]    mem_q [Depth];
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                full;
  logic                do_push;
  logic                do_pop;

  assign empty_o = (count_q == '0);
  assign full    = (count_q == CntWidth'(Depth));
  assign do_pop  = pop_i & ~empty_o;
  assign do_push = push_i & (~full | pop_i);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + PtrWidth'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + PtrWidth'(1);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + CntWidth'(1);
      end else if (do_pop && !do_push) begin
        count_q <= count_q - CntWidth'(1);
      end
    end
  end

  // Storage, written at the tail
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/opq_decode.sv ====
/*
 * Command buffer with decode of the head conversion code.
 * A conversion whose destination would be wider than 64 bits acts as ConvNone.
 */

`default_nettype none

module opq_decode (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              cmd_valid_i,
  input  opq_pkg::eew_e                     cmd_eew_i,
  input  opq_pkg::conv_e                    cmd_conv_i,
  input  logic [opq_pkg::ElemCntWidth-1:0]  cmd_elem_count_i,
  input  logic                              cmd_pop_i,
  output logic                              cmd_present_o,
  output opq_pkg::eew_e                     eew_o,
  output logic [1:0]                        factor_o,
  output logic                              signed_o,
  output logic [opq_pkg::ElemCntWidth-1:0]  elem_count_o
);

  logic [opq_pkg::CmdWidth-1:0] cmd_head;
  logic                         cmd_empty;
  opq_pkg::conv_e               head_conv;
  logic [1:0]                   raw_factor;
  logic                         raw_signed;

  opq_fifo #(
    .Width (opq_pkg::CmdWidth),
    .Depth (opq_pkg::CmdDepth)
  ) i_cmd_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (cmd_valid_i),
    .data_i  ({cmd_eew_i, cmd_conv_i, cmd_elem_count_i}),
    .pop_i   (cmd_pop_i),
    .data_o  (cmd_head),
    .empty_o (cmd_empty)
  );

  assign cmd_present_o = ~cmd_empty;
  assign eew_o         = opq_pkg::eew_e'(cmd_head[opq_pkg::CmdWidth-1 -: $bits(opq_pkg::eew_e)]);
  assign head_conv     = opq_pkg::conv_e'(cmd_head[opq_pkg::ElemCntWidth +: $bits(opq_pkg::conv_e)]);
  assign elem_count_o  = cmd_head[opq_pkg::ElemCntWidth-1:0];

  // Widening factor as log2 of F
  always_comb begin
    unique case (head_conv)
      opq_pkg::ConvSExt2: {raw_factor, raw_signed} = {2'd1, 1'b1};
      opq_pkg::ConvZExt2: {raw_factor, raw_signed} = {2'd1, 1'b0};
      opq_pkg::ConvSExt4: {raw_factor, raw_signed} = {2'd2, 1'b1};
      opq_pkg::ConvZExt4: {raw_factor, raw_signed} = {2'd2, 1'b0};
      opq_pkg::ConvSExt8: {raw_factor, raw_signed} = {2'd3, 1'b1};
      opq_pkg::ConvZExt8: {raw_factor, raw_signed} = {2'd3, 1'b0};
      default:            {raw_factor, raw_signed} = {2'd0, 1'b0};
    endcase
  end

  // Destination element must still fit in one word
  always_comb begin
    if (({1'b0, eew_o} + {1'b0, raw_factor}) > 3'd3) begin
      factor_o = 2'd0;
      signed_o = 1'b0;
    end else begin
      factor_o = raw_factor;
      signed_o = raw_signed;
    end
  end

endmodule

`default_nettype wire

// ==== hw/opq_execute.sv ====
/*
 * Operand buffer, credit counter and integer widening datapath.
 * The output word is combinational from the buffer head and the select pointer.
 * Factor and element width are assumed already clamped to fit 64 bits.
 */

`default_nettype none

module opq_execute (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [opq_pkg::ElenWidth-1:0]   operand_i,
  input  logic                            operand_valid_i,
  input  logic                            operand_issued_i,
  input  logic                            ibuf_pop_i,
  input  logic [opq_pkg::SelWidth-1:0]    select_i,
  input  opq_pkg::eew_e                   eew_i,
  input  logic [1:0]                      factor_i,
  input  logic                            signed_i,
  output logic                            operand_queue_ready_o,
  output logic                            word_present_o,
  output logic [opq_pkg::ElenWidth-1:0]   operand_o
);

  localparam int unsigned SelW = opq_pkg::SelWidth;
  localparam int unsigned CrdW = opq_pkg::CreditWidth;

  logic [opq_pkg::ElenWidth-1:0] ibuf_head;
  logic                          ibuf_empty;
  logic [CrdW-1:0]               credit_d;
  logic [CrdW-1:0]               credit_q;

  ////////////////////////////////////////////////////////////////////////////
  // Operand buffer and credits
  ////////////////////////////////////////////////////////////////////////////

  opq_fifo #(
    .Width (opq_pkg::ElenWidth),
    .Depth (opq_pkg::DataDepth)
  ) i_operand_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (operand_valid_i),
    .data_i  (operand_i),
    .pop_i   (ibuf_pop_i),
    .data_o  (ibuf_head),
    .empty_o (ibuf_empty)
  );

  assign word_present_o = ~ibuf_empty;

  // One credit per word announced but not yet consumed
  always_comb begin
    credit_d = credit_q;
    if (operand_issued_i) begin
      credit_d = credit_d + CrdW'(1);
    end
    if (ibuf_pop_i) begin
      credit_d = credit_d - CrdW'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_d;
    end
  end

  assign operand_queue_ready_o = (credit_q < CrdW'(opq_pkg::DataDepth));

  ////////////////////////////////////////////////////////////////////////////
  // Widening datapath
  ////////////////////////////////////////////////////////////////////////////

  // Each output byte is either a source byte or an extension byte
  always_comb begin : p_widen
    logic [2:0]      shift;
    logic [SelW-1:0] src_mask;
    logic [SelW-1:0] dst_mask;
    logic [SelW-1:0] byte_idx;
    logic [SelW-1:0] elem_base;
    logic [SelW-1:0] src_idx;
    logic [SelW-1:0] top_idx;

    // log2 of destination element bytes
    shift    = {1'b0, eew_i} + {1'b0, factor_i};
    src_mask = SelW'((4'd1 << eew_i) - 4'd1);
    dst_mask = SelW'((4'd1 << shift) - 4'd1);
    for (int unsigned b = 0; b < opq_pkg::ElenBytes; b++) begin
      byte_idx  = SelW'(b);
      // Source offset of the element that owns this output byte
      elem_base = (byte_idx >> shift) << eew_i;
      src_idx   = select_i + elem_base + (byte_idx & dst_mask);
      top_idx   = select_i + elem_base + src_mask;
      if ((byte_idx & dst_mask) <= src_mask) begin
        operand_o[8*b +: 8] = ibuf_head[8*src_idx +: 8];
      end else begin
        operand_o[8*b +: 8] = {8{signed_i & ibuf_head[8*top_idx + 7]}};
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/opq_result.sv ====
/*
 * Transfer accounting. Counts produced elements, steps the byte select and
 * pops the operand and command buffers. Valid is combinational from both heads.
 */

`default_nettype none

module opq_result (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              cmd_present_i,
  input  logic                              word_present_i,
  input  logic                              operand_ready_i,
  input  opq_pkg::eew_e                     eew_i,
  input  logic [1:0]                        factor_i,
  input  logic [opq_pkg::ElemCntWidth-1:0]  elem_count_i,
  output logic                              operand_valid_o,
  output logic [opq_pkg::SelWidth-1:0]      select_o,
  output logic                              ibuf_pop_o,
  output logic                              cmd_pop_o
);

  localparam int unsigned CntW = opq_pkg::ElemCntWidth;
  localparam int unsigned SelW = opq_pkg::SelWidth;

  logic            transfer;
  logic [CntW-1:0] count_d;
  logic [CntW-1:0] count_q;
  logic [CntW:0]   count_sum;
  logic [SelW-1:0] select_d;
  logic [SelW-1:0] select_q;
  logic [CntW-1:0] elem_step;
  logic [SelW-1:0] sel_step;

  assign operand_valid_o = cmd_present_i & word_present_i;
  assign transfer        = operand_valid_o & operand_ready_i;
  assign select_o        = select_q;

  // Elements per output word, (8 >> eew) / F
  assign elem_step = CntW'((opq_pkg::ElenBytes >> eew_i) >> factor_i);
  // Source bytes consumed per output word, wraps to 0 when F is 1
  assign sel_step  = SelW'(opq_pkg::ElenBytes >> factor_i);
  assign count_sum = {1'b0, count_q} + {1'b0, elem_step};

  ////////////////////////////////////////////////////////////////////////////
  // Pop control
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    count_d    = count_q;
    select_d   = select_q;
    ibuf_pop_o = 1'b0;
    cmd_pop_o  = 1'b0;
    if (transfer) begin
      count_d  = count_sum[CntW-1:0];
      select_d = select_q + sel_step;
      // Word fully used
      if ((select_q != '0 && select_d == '0) || factor_i == 2'd0) begin
        ibuf_pop_o = 1'b1;
      end
      // Command done, the rest of the word is dropped
      if (count_sum >= {1'b0, elem_count_i}) begin
        ibuf_pop_o = 1'b1;
        cmd_pop_o  = 1'b1;
        count_d    = '0;
        select_d   = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q  <= '0;
      select_q <= '0;
    end else begin
      count_q  <= count_d;
      select_q <= select_d;
    end
  end

endmodule

`default_nettype wire

// ==== hw/opq_top.sv ====
/*
 * Vector operand queue between a register file and a single functional unit.
 * The requester pushes commands only when it knows there is room.
 */

`default_nettype none

module opq_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              cmd_valid_i,
  input  opq_pkg::eew_e                     cmd_eew_i,
  input  opq_pkg::conv_e                    cmd_conv_i,
  input  logic [opq_pkg::ElemCntWidth-1:0]  cmd_elem_count_i,
  input  logic [opq_pkg::ElenWidth-1:0]     operand_i,
  input  logic                              operand_valid_i,
  input  logic                              operand_issued_i,
  output logic                              operand_queue_ready_o,
  output logic [opq_pkg::ElenWidth-1:0]     operand_o,
  output logic                              operand_valid_o,
  input  logic                              operand_ready_i
);

  logic                              cmd_present;
  opq_pkg::eew_e                     cmd_eew;
  logic [1:0]                        cmd_factor;
  logic                              cmd_signed;
  logic [opq_pkg::ElemCntWidth-1:0]  cmd_elem_count;
  logic                              cmd_pop;
  logic                              word_present;
  logic [opq_pkg::SelWidth-1:0]      select;
  logic                              ibuf_pop;

  opq_decode i_decode (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_eew_i        (cmd_eew_i),
    .cmd_conv_i       (cmd_conv_i),
    .cmd_elem_count_i (cmd_elem_count_i),
    .cmd_pop_i        (cmd_pop),
    .cmd_present_o    (cmd_present),
    .eew_o            (cmd_eew),
    .factor_o         (cmd_factor),
    .signed_o         (cmd_signed),
    .elem_count_o     (cmd_elem_count)
  );

  opq_execute i_execute (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .operand_i             (operand_i),
    .operand_valid_i       (operand_valid_i),
    .operand_issued_i      (operand_issued_i),
    .ibuf_pop_i            (ibuf_pop),
    .select_i              (select),
    .eew_i                 (cmd_eew),
    .factor_i              (cmd_factor),
    .signed_i              (cmd_signed),
    .operand_queue_ready_o (operand_queue_ready_o),
    .word_present_o        (word_present),
    .operand_o             (operand_o)
  );

  opq_result i_result (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_present_i   (cmd_present),
    .word_present_i  (word_present),
    .operand_ready_i (operand_ready_i),
    .eew_i           (cmd_eew),
    .factor_i        (cmd_factor),
    .elem_count_i    (cmd_elem_count),
    .operand_valid_o (operand_valid_o),
    .select_o        (select),
    .ibuf_pop_o      (ibuf_pop),
    .cmd_pop_o       (cmd_pop)
  );

endmodule

`default_nettype wire

// ==== dv/opq_asserts.sv ====
/*
 * Protocol checks on the operand queue top level, attached with bind.
 * fail_count holds the number of failed checks for the closing summary.
 */

`default_nettype none

module opq_asserts (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          word_push_i,
  input  logic                          queue_ready_i,
  input  logic [opq_pkg::ElenWidth-1:0] data_i,
  input  logic                          valid_i,
  input  logic                          ready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int   fail_count = 0;
  logic pushed_q;

  // Set by the first operand word ever pushed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pushed_q <= 1'b0;
    end else if (word_push_i) begin
      pushed_q <= 1'b1;
    end
  end

  // Back-pressure holds the offered word
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (valid_i && !ready_i) |=> (valid_i && $stable(data_i)))
    else begin
      $error("Output word changed or was withdrawn under back-pressure");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   $rose(valid_i) |-> pushed_q)
    else begin
      $error("Output valid rose before any operand word was pushed");
      fail_count++;
    end

  // First cycle out of reset
  assert property (@(posedge clk_i) $rose(rst_ni) |-> (queue_ready_i && !valid_i))
    else begin
      $error("Queue not idle in the first cycle after reset");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== dv/opq_tb.sv ====
/*
 * Testbench for the vector operand queue. Expected words come from a model of
 * the integer widening rules. The requester keeps at most CmdDepth commands
 * outstanding and issues a word only while operand_queue_ready_o is high.
 */

`default_nettype none

module opq_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MaxCycles = 2000;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             cmd_valid_i;
  opq_pkg::eew_e                    cmd_eew_i;
  opq_pkg::conv_e                   cmd_conv_i;
  logic [opq_pkg::ElemCntWidth-1:0] cmd_elem_count_i;
  logic [opq_pkg::ElenWidth-1:0]    operand_i;
  logic                             operand_valid_i;
  logic                             operand_issued_i;
  logic                             operand_queue_ready_o;
  logic [opq_pkg::ElenWidth-1:0]    operand_o;
  logic                             operand_valid_o;
  logic                             operand_ready_i;

  integer      seed = 7;
  int          errors = 0;
  int          cycles = 0;
  int          tb_credit = 0;
  int          cmds_pushed = 0;
  int          cmds_done = 0;
  bit          random_ready = 1'b0;
  bit          ready_draw = 1'b0;
  logic [63:0] exp_q [$];
  bit          pop_q [$];
  bit          last_q [$];
  logic [63:0] exp_head = '0;
  bit          exp_avail = 1'b0;

  opq_top UUT (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .cmd_valid_i           (cmd_valid_i),
    .cmd_eew_i             (cmd_eew_i),
    .cmd_conv_i            (cmd_conv_i),
    .cmd_elem_count_i      (cmd_elem_count_i),
    .operand_i             (operand_i),
    .operand_valid_i       (operand_valid_i),
    .operand_issued_i      (operand_issued_i),
    .operand_queue_ready_o (operand_queue_ready_o),
    .operand_o             (operand_o),
    .operand_valid_o       (operand_valid_o),
    .operand_ready_i       (operand_ready_i)
  );

  bind opq_top opq_asserts i_asserts (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .word_push_i   (operand_valid_i),
    .queue_ready_i (operand_queue_ready_o),
    .data_i        (operand_o),
    .valid_i       (operand_valid_o),
    .ready_i       (operand_ready_i)
  );

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Factor as log2 of F
  // Too wide a destination falls back to a plain copy
  function automatic void conv_params(input int eew, input opq_pkg::conv_e conv,
                                      output int fct, output bit sgn);
    case (conv)
      opq_pkg::ConvSExt2, opq_pkg::ConvZExt2: fct = 1;
      opq_pkg::ConvSExt4, opq_pkg::ConvZExt4: fct = 2;
      opq_pkg::ConvSExt8, opq_pkg::ConvZExt8: fct = 3;
      default: fct = 0;
    endcase
    sgn = conv inside {opq_pkg::ConvSExt2, opq_pkg::ConvSExt4, opq_pkg::ConvSExt8};
    if (eew + fct > 3) begin
      fct = 0;
      sgn = 1'b0;
    end
  endfunction

  function automatic logic [63:0] widen(input logic [63:0] word, input int eew,
                                        input int fct, input bit sgn, input int sel);
    int          esize;
    int          dsize;
    logic [63:0] smask;
    logic [63:0] dmask;
    logic [63:0] elem;
    logic [63:0] res;
    esize = 8 << eew;
    dsize = esize << fct;
    smask = (esize == 64) ? '1 : (64'd1 << esize) - 64'd1;
    dmask = (dsize == 64) ? '1 : (64'd1 << dsize) - 64'd1;
    res   = '0;
    for (int k = 0; k < 64 / dsize; k++) begin
      elem = (word >> (8 * sel + k * esize)) & smask;
      if (sgn && elem[esize-1]) begin
        elem = elem | ~smask;
      end
      res = res | ((elem & dmask) << (k * dsize));
    end
    return res;
  endfunction

  task automatic refresh_head();
    exp_avail = (exp_q.size() > 0);
    exp_head  = exp_avail ? exp_q[0] : '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic push_word(input logic [63:0] word);
    while (!operand_queue_ready_o) begin
      @(negedge clk_i);
    end
    operand_issued_i = 1'b1;
    @(negedge clk_i);
    operand_issued_i = 1'b0;
    operand_valid_i  = 1'b1;
    operand_i        = word;
    @(negedge clk_i);
    operand_valid_i = 1'b0;
  endtask

  // Pushes one command and its words and queues every expected output word
  task automatic send_cmd(input opq_pkg::eew_e eew, input opq_pkg::conv_e conv,
                          input int count, input bit neg);
    int          fct;
    bit          sgn;
    int          per_word;
    int          elems;
    logic [63:0] word;
    bit          last;
    conv_params(eew, conv, fct, sgn);
    per_word = 8 >> eew;
    while (cmds_pushed - cmds_done >= opq_pkg::CmdDepth) begin
      @(negedge clk_i);
    end
    cmd_valid_i      = 1'b1;
    cmd_eew_i        = eew;
    cmd_conv_i       = conv;
    cmd_elem_count_i = count[opq_pkg::ElemCntWidth-1:0];
    cmds_pushed++;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    elems = 0;
    for (int w = 0; w < (count + per_word - 1) / per_word; w++) begin
      word = {$random(seed), $random(seed)};
      if (neg) begin
        word = word | 64'h8080_8080_8080_8080;
      end
      for (int j = 0; j < (1 << fct) && elems < count; j++) begin
        elems += per_word >> fct;
        last = (elems >= count);
        exp_q.push_back(widen(word, eew, fct, sgn, (j * 8) >> fct));
        pop_q.push_back(last || j == (1 << fct) - 1);
        last_q.push_back(last);
      end
      refresh_head();
      push_word(word);
    end
  endtask

  // Ready is drawn at the rising edge and applied at the falling edge
  always @(posedge clk_i) begin
    ready_draw = random_ready ? (($random(seed) % 4) != 0) : 1'b0;
  end

  always @(negedge clk_i) begin
    operand_ready_i <= ready_draw;
  end

  // Tracks consumed words and finished commands
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (operand_issued_i) begin
        tb_credit++;
      end
      if (operand_valid_o && operand_ready_i && exp_q.size() > 0) begin
        if (pop_q[0]) begin
          tb_credit--;
        end
        if (last_q[0]) begin
          cmds_done++;
        end
        void'(exp_q.pop_front());
        void'(pop_q.pop_front());
        void'(last_q.pop_front());
        refresh_head();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (operand_valid_o && operand_ready_i) |-> exp_avail)
    else begin
      $display("Output word transferred at %0t with no word expected", $time);
      errors++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (operand_valid_o && operand_ready_i && exp_avail) |-> operand_o == exp_head)
    else begin
      $display("FAIL %0t operand_o expected %h actual %h", $time, $sampled(exp_head),
               $sampled(operand_o));
      errors++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   operand_queue_ready_o == (tb_credit < opq_pkg::DataDepth))
    else begin
      $display("FAIL %0t operand_queue_ready_o expected %0b actual %0b", $time,
               $sampled(tb_credit) < opq_pkg::DataDepth, $sampled(operand_queue_ready_o));
      errors++;
    end

  task automatic finish_run();
    $display("Errors: %0d value, %0d protocol", errors, UUT.i_asserts.fail_count);
    if (errors == 0 && UUT.i_asserts.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles == MaxCycles) begin
      $display("Timeout after %0d cycles with %0d words pending", cycles, exp_q.size());
      errors++;
      finish_run();
    end
  end

  initial begin
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    cmd_valid_i      = 1'b0;
    cmd_eew_i        = opq_pkg::EW8;
    cmd_conv_i       = opq_pkg::ConvNone;
    cmd_elem_count_i = '0;
    operand_i        = '0;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    operand_ready_i  = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // Two words fill the credits while the consumer is stalled
    send_cmd(opq_pkg::EW8, opq_pkg::ConvNone, 16, 1'b0);
    repeat (4) @(negedge clk_i);
    random_ready = 1'b1;
    send_cmd(opq_pkg::EW64, opq_pkg::ConvNone, 2, 1'b0);
    send_cmd(opq_pkg::EW8, opq_pkg::ConvZExt2, 16, 1'b1);
    send_cmd(opq_pkg::EW16, opq_pkg::ConvZExt4, 8, 1'b1);
    send_cmd(opq_pkg::EW8, opq_pkg::ConvSExt2, 8, 1'b1);
    send_cmd(opq_pkg::EW16, opq_pkg::ConvSExt4, 4, 1'b1);
    send_cmd(opq_pkg::EW8, opq_pkg::ConvSExt8, 8, 1'b0);
    send_cmd(opq_pkg::EW32, opq_pkg::ConvSExt2, 4, 1'b1);
    // The next command starts on a fresh word after one that ends mid-word
    send_cmd(opq_pkg::EW8, opq_pkg::ConvZExt4, 3, 1'b0);
    send_cmd(opq_pkg::EW8, opq_pkg::ConvNone, 8, 1'b0);
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== list.f ====
hw/opq_pkg.sv
hw/opq_fifo.sv
hw/opq_decode.sv
hw/opq_execute.sv
hw/opq_result.sv
hw/opq_top.sv
dv/opq_asserts.sv
dv/opq_tb.sv

// ==== Bender.yml ====
package:
  name: opq

sources:
  - hw/opq_pkg.sv
  - hw/opq_fifo.sv
  - hw/opq_decode.sv
  - hw/opq_execute.sv
  - hw/opq_result.sv
  - hw/opq_top.sv
  - target: test
    files:
      - dv/opq_asserts.sv
      - dv/opq_tb.sv
